// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal -j 0
TOP       = stat_core_tb
FILELIST  = sources.f

OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: sources.f
src/stat_pkg.sv
src/mac_event_pkg.sv
src/port_stat_gen.sv
src/stat_arb_mux.sv
src/stat_counter_bank.sv
src/stat_core.sv
testbench/stat_core_props.sv
testbench/stat_core_tb.sv

// File: src/mac_event_pkg.sv
// ethernet frame event definitions
package mac_event_pkg;

    // frame length in bytes
    typedef logic [13:0] frame_len_t;

    // finished frame as reported by a port
    typedef struct packed {
        frame_len_t len;
        // frame check passed
        logic       good;
        // broadcast destination
        logic       bcast;
    } frame_event_s;

    // counters owned by each port
    localparam int unsigned PORT_STAT_SLOTS = 4;

    // counter offsets within a port's block
    localparam int unsigned SLOT_GOOD_FRAMES  = 0;
    localparam int unsigned SLOT_BAD_FRAMES   = 1;
    localparam int unsigned SLOT_GOOD_BYTES   = 2;
    localparam int unsigned SLOT_BCAST_FRAMES = 3;

endpackage

// File: src/port_stat_gen.sv
// per-port statistic increment generator
`timescale 1ns/1ps

module port_stat_gen #(
    // first counter id of this port, a multiple of 4
    parameter int STAT_ID_BASE = 0
) (
    input  wire logic                        clk,
    input  wire logic                        rst,

    // frame events from the port
    input  wire logic                        evt_valid,
    input  wire mac_event_pkg::frame_event_s evt,
    output wire logic                        evt_ready,

    // statistic increments
    output wire logic                        inc_valid,
    output wire stat_pkg::stat_inc_s         inc,
    input  wire logic                        inc_ready
);

    import stat_pkg::*;
    import mac_event_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        GOOD,
        BYTES,
        BCAST,
        BAD
    } state_t;

    state_t       state_reg;
    state_t       state_next;
    frame_event_s evt_reg;
    stat_inc_s    inc_int;
    logic         inc_done;

    // one event at a time, taken only while idle
    assign evt_ready = state_reg == IDLE;
    assign inc_valid = state_reg != IDLE;
    assign inc = inc_int;
    assign inc_done = inc_valid && inc_ready;

    // increment for the current state
    always_comb begin
        inc_int.id = stat_id_t'(STAT_ID_BASE + SLOT_GOOD_FRAMES);
        inc_int.amount = stat_inc_t'(1);
        case (state_reg)
            BYTES: begin
                inc_int.id = stat_id_t'(STAT_ID_BASE + SLOT_GOOD_BYTES);
                inc_int.amount = stat_inc_t'(evt_reg.len);
            end
            BCAST: begin
                inc_int.id = stat_id_t'(STAT_ID_BASE + SLOT_BCAST_FRAMES);
            end
            BAD: begin
                inc_int.id = stat_id_t'(STAT_ID_BASE + SLOT_BAD_FRAMES);
            end
            default: begin
            end
        endcase
    end

    // good: frames, bytes, then bcast if flagged
    // bad: a single bad frame count
    always_comb begin
        state_next = state_reg;
        case (state_reg)
            IDLE: begin
                if (evt_valid) begin
                    state_next = evt.good ? GOOD : BAD;
                end
            end
            GOOD: begin
                if (inc_done) begin
                    state_next = BYTES;
                end
            end
            BYTES: begin
                if (inc_done) begin
                    state_next = evt_reg.bcast ? BCAST : IDLE;
                end
            end
            default: begin
                if (inc_done) begin
                    state_next = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= IDLE;
        end else begin
            state_reg <= state_next;
        end
    end

    // hold the accepted event for the whole series
    always_ff @(posedge clk) begin
        if (evt_valid && evt_ready) begin
            evt_reg <= evt;
        end
    end

endmodule

// File: src/stat_arb_mux.sv
// round-robin increment stream mux
`timescale 1ns/1ps

module stat_arb_mux (
    input  wire logic                clk,
    input  wire logic                rst,

    // input stream 0
    input  wire logic                s0_valid,
    input  wire stat_pkg::stat_inc_s s0,
    output wire logic                s0_ready,

    // input stream 1
    input  wire logic                s1_valid,
    input  wire stat_pkg::stat_inc_s s1,
    output wire logic                s1_ready,

    // merged output stream
    output wire logic                m_valid,
    output wire stat_pkg::stat_inc_s m,
    input  wire logic                m_ready
);

    import stat_pkg::*;

    stat_inc_s m_reg;
    logic      m_valid_reg;
    logic      last_s1_reg;
    logic      load_en;
    logic      sel0;
    logic      sel1;

    // output register is free, or drains this cycle
    assign load_en = !m_valid_reg || m_ready;

    // on a tie, grant whichever input lost last time
    assign sel1 = s1_valid && (!s0_valid || !last_s1_reg);
    assign sel0 = s0_valid && !sel1;

    assign s0_ready = load_en && sel0;
    assign s1_ready = load_en && sel1;

    assign m_valid = m_valid_reg;
    assign m = m_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid_reg <= 1'b0;
            // port 0 wins the first tie
            last_s1_reg <= 1'b1;
        end else if (load_en) begin
            m_valid_reg <= sel0 || sel1;
            if (sel0 || sel1) begin
                last_s1_reg <= sel1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en && sel1) begin
            m_reg <= s1;
        end else if (load_en && sel0) begin
            m_reg <= s0;
        end
    end

endmodule

// File: src/stat_core.sv
// two-port statistics core
`timescale 1ns/1ps

module stat_core (
    input  wire logic                        clk,
    input  wire logic                        rst,

    // event port 0
    input  wire logic                        evt0_valid,
    input  wire mac_event_pkg::frame_event_s evt0,
    output wire logic                        evt0_ready,

    // event port 1
    input  wire logic                        evt1_valid,
    input  wire mac_event_pkg::frame_event_s evt1,
    output wire logic                        evt1_ready,

    // management read request
    input  wire logic                        rd_req_valid,
    input  wire stat_pkg::stat_id_t          rd_req_id,
    output wire logic                        rd_req_ready,

    // management read response
    output wire logic                        rd_resp_valid,
    output wire stat_pkg::stat_cnt_t         rd_resp_data,
    input  wire logic                        rd_resp_ready
);

    import stat_pkg::*;
    import mac_event_pkg::*;

    // per-port increment streams
    wire logic      inc0_valid;
    wire stat_inc_s inc0;
    wire logic      inc0_ready;
    wire logic      inc1_valid;
    wire stat_inc_s inc1;
    wire logic      inc1_ready;

    // merged increment stream
    wire logic      inc_valid;
    wire stat_inc_s inc;
    wire logic      inc_ready;

    port_stat_gen #(
        .STAT_ID_BASE(0)
    )
    port0_stat (
        .clk(clk),
        .rst(rst),
        .evt_valid(evt0_valid),
        .evt(evt0),
        .evt_ready(evt0_ready),
        .inc_valid(inc0_valid),
        .inc(inc0),
        .inc_ready(inc0_ready)
    );

    // port 1 owns the next block of counters
    port_stat_gen #(
        .STAT_ID_BASE(PORT_STAT_SLOTS)
    )
    port1_stat (
        .clk(clk),
        .rst(rst),
        .evt_valid(evt1_valid),
        .evt(evt1),
        .evt_ready(evt1_ready),
        .inc_valid(inc1_valid),
        .inc(inc1),
        .inc_ready(inc1_ready)
    );

    stat_arb_mux stat_mux (
        .clk(clk),
        .rst(rst),
        .s0_valid(inc0_valid),
        .s0(inc0),
        .s0_ready(inc0_ready),
        .s1_valid(inc1_valid),
        .s1(inc1),
        .s1_ready(inc1_ready),
        .m_valid(inc_valid),
        .m(inc),
        .m_ready(inc_ready)
    );

    stat_counter_bank stat_bank (
        .clk(clk),
        .rst(rst),
        .inc_valid(inc_valid),
        .inc(inc),
        .inc_ready(inc_ready),
        .rd_req_valid(rd_req_valid),
        .rd_req_id(rd_req_id),
        .rd_req_ready(rd_req_ready),
        .rd_resp_valid(rd_resp_valid),
        .rd_resp_data(rd_resp_data),
        .rd_resp_ready(rd_resp_ready)
    );

endmodule

// File: src/stat_counter_bank.sv
// statistics counter bank
`timescale 1ns/1ps

module stat_counter_bank (
    input  wire logic                clk,
    input  wire logic                rst,

    // increment stream
    input  wire logic                inc_valid,
    input  wire stat_pkg::stat_inc_s inc,
    output wire logic                inc_ready,

    // read request
    input  wire logic                rd_req_valid,
    input  wire stat_pkg::stat_id_t  rd_req_id,
    output wire logic                rd_req_ready,

    // read response
    output wire logic                rd_resp_valid,
    output wire stat_pkg::stat_cnt_t rd_resp_data,
    input  wire logic                rd_resp_ready
);

    import stat_pkg::*;

    stat_cnt_t cnt_mem [STAT_COUNT];

    stat_cnt_t rd_resp_data_reg;
    logic      rd_resp_valid_reg;
    logic      rd_req_accept;

    // read-modify-write terms
    logic      inc_accept;
    stat_id_t  inc_id;
    stat_cnt_t cnt_old;
    stat_cnt_t cnt_new;

    // one increment per cycle, never stalls
    assign inc_ready = 1'b1;
    assign inc_accept = inc_valid && inc_ready;

    assign inc_id = inc.id;
    assign cnt_old = cnt_mem[inc_id];
    // plain 32-bit add, wraps on overflow
    assign cnt_new = cnt_old + stat_cnt_t'(inc.amount);

    // response slot free, or being emptied this cycle
    assign rd_req_ready = !rd_resp_valid_reg || rd_resp_ready;
    assign rd_req_accept = rd_req_valid && rd_req_ready;

    assign rd_resp_valid = rd_resp_valid_reg;
    assign rd_resp_data = rd_resp_data_reg;

    // counter update, whole array cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAT_COUNT; i++) begin
                cnt_mem[i] <= '0;
            end
        end else if (inc_accept) begin
            cnt_mem[inc_id] <= cnt_new;
        end
    end

    // response valid follows the accepted request by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_resp_valid_reg <= 1'b0;
        end else if (rd_req_accept) begin
            rd_resp_valid_reg <= 1'b1;
        end else if (rd_resp_ready) begin
            rd_resp_valid_reg <= 1'b0;
        end
    end

    // samples the value before a same-edge increment lands
    always_ff @(posedge clk) begin
        if (rd_req_accept) begin
            rd_resp_data_reg <= cnt_mem[rd_req_id];
        end
    end

endmodule

// File: src/stat_pkg.sv
// statistics counter definitions
package stat_pkg;

    // size of the counter bank
    localparam int STAT_COUNT = 32;

    // counter id, wide enough to address every counter
    localparam int STAT_ID_W = 5;

    // amount carried by one increment
    localparam int STAT_INC_W = 16;

    // counter width, wraps modulo 2^32
    localparam int STAT_CNT_W = 32;

    typedef logic [STAT_ID_W-1:0] stat_id_t;

    typedef logic [STAT_INC_W-1:0] stat_inc_t;

    typedef logic [STAT_CNT_W-1:0] stat_cnt_t;

    // one statistic increment
    // id sits in the upper bits, amount below it
    typedef struct packed {
        stat_id_t  id;
        stat_inc_t amount;
    } stat_inc_s;

endpackage

// File: testbench/stat_core_props.sv
// statistics core handshake checks
`timescale 1ns/1ps

module stat_core_props (
    input wire logic                        clk,
    input wire logic                        rst,

    // event ports
    input wire logic                        evt0_valid,
    input wire mac_event_pkg::frame_event_s evt0,
    input wire logic                        evt0_ready,
    input wire logic                        evt1_valid,
    input wire mac_event_pkg::frame_event_s evt1,
    input wire logic                        evt1_ready,

    // read response
    input wire logic                        rd_resp_valid,
    input wire stat_pkg::stat_cnt_t         rd_resp_data,
    input wire logic                        rd_resp_ready
);

    int fail_count = 0;

    // stalled response keeps valid and data
    resp_stable: assert property (@(posedge clk) disable iff (rst)
        rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp_data))
    else begin
        $error("read response changed while rd_resp_ready was low");
        fail_count++;
    end

    // an event waiting for ready must not change
    evt0_stable: assert property (@(posedge clk) disable iff (rst)
        evt0_valid && !evt0_ready |=> evt0_valid && $stable(evt0))
    else begin
        $error("port 0 event dropped or changed before it was accepted");
        fail_count++;
    end

    evt1_stable: assert property (@(posedge clk) disable iff (rst)
        evt1_valid && !evt1_ready |=> evt1_valid && $stable(evt1))
    else begin
        $error("port 1 event dropped or changed before it was accepted");
        fail_count++;
    end

    // no response out of reset
    resp_reset: assert property (@(posedge clk) rst |=> !rd_resp_valid)
    else begin
        $error("read response valid during or right after reset");
        fail_count++;
    end

endmodule

bind stat_core stat_core_props stat_props (
    .clk(clk),
    .rst(rst),
    .evt0_valid(evt0_valid),
    .evt0(evt0),
    .evt0_ready(evt0_ready),
    .evt1_valid(evt1_valid),
    .evt1(evt1),
    .evt1_ready(evt1_ready),
    .rd_resp_valid(rd_resp_valid),
    .rd_resp_data(rd_resp_data),
    .rd_resp_ready(rd_resp_ready)
);

// File: testbench/stat_core_tb.sv
// statistics core testbench
`timescale 1ns/1ps

module stat_core_tb;

    import stat_pkg::*;
    import mac_event_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;
    localparam int DRAIN_CYCLES = 8;
    localparam int RANDOM_EVENTS = 200;

    logic         clk;
    logic         rst;
    logic         evt0_valid;
    frame_event_s evt0;
    logic         evt0_ready;
    logic         evt1_valid;
    frame_event_s evt1;
    logic         evt1_ready;
    logic         rd_req_valid;
    stat_id_t     rd_req_id;
    logic         rd_req_ready;
    logic         rd_resp_valid;
    stat_cnt_t    rd_resp_data;
    logic         rd_resp_ready;

    // expected counter values
    stat_cnt_t    ref_cnt [STAT_COUNT];
    integer       seed;
    int           errors;
    int           cycle_count;

    stat_core uut (
        .clk(clk),
        .rst(rst),
        .evt0_valid(evt0_valid),
        .evt0(evt0),
        .evt0_ready(evt0_ready),
        .evt1_valid(evt1_valid),
        .evt1(evt1),
        .evt1_ready(evt1_ready),
        .rd_req_valid(rd_req_valid),
        .rd_req_id(rd_req_id),
        .rd_req_ready(rd_req_ready),
        .rd_resp_valid(rd_resp_valid),
        .rd_resp_data(rd_resp_data),
        .rd_resp_ready(rd_resp_ready)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // counter updates implied by one accepted event
    function automatic void count_event(input stat_id_t base, input frame_event_s ev);
        stat_id_t frames_id;
        stat_id_t bad_id;
        stat_id_t bytes_id;
        stat_id_t bcast_id;
        frames_id = base + stat_id_t'(SLOT_GOOD_FRAMES);
        bad_id = base + stat_id_t'(SLOT_BAD_FRAMES);
        bytes_id = base + stat_id_t'(SLOT_GOOD_BYTES);
        bcast_id = base + stat_id_t'(SLOT_BCAST_FRAMES);
        if (ev.good) begin
            ref_cnt[frames_id] = ref_cnt[frames_id] + 32'd1;
            ref_cnt[bytes_id] = ref_cnt[bytes_id] + stat_cnt_t'(ev.len);
            if (ev.bcast) begin
                ref_cnt[bcast_id] = ref_cnt[bcast_id] + 32'd1;
            end
        end else begin
            ref_cnt[bad_id] = ref_cnt[bad_id] + 32'd1;
        end
    endfunction

    always @(posedge clk) begin
        if (!rst && evt0_valid && evt0_ready) begin
            count_event(stat_id_t'(0), evt0);
        end
        if (!rst && evt1_valid && evt1_ready) begin
            count_event(stat_id_t'(PORT_STAT_SLOTS), evt1);
        end
    end

    // mode 1 forces a good frame and mode 2 a bad one
    function automatic frame_event_s random_event(input int mode);
        frame_event_s ev;
        integer r;
        r = $random(seed);
        ev.len = r[13:0];
        ev.bcast = r[20];
        if (mode == 1) begin
            ev.good = 1'b1;
        end else if (mode == 2) begin
            ev.good = 1'b0;
        end else begin
            ev.good = r[19:17] != 3'd0;
        end
        return ev;
    endfunction

    task automatic send_event(input int port, input frame_event_s ev);
        if (port == 0) begin
            evt0_valid <= 1'b1;
            evt0 <= ev;
            @(posedge clk);
            while (!evt0_ready) begin
                @(posedge clk);
            end
            evt0_valid <= 1'b0;
        end else begin
            evt1_valid <= 1'b1;
            evt1 <= ev;
            @(posedge clk);
            while (!evt1_ready) begin
                @(posedge clk);
            end
            evt1_valid <= 1'b0;
        end
    endtask

    // wait until both ports stay idle long enough for the bank to catch up
    task automatic drain();
        int idle;
        idle = 0;
        while (idle < DRAIN_CYCLES) begin
            @(posedge clk);
            if (evt0_ready && evt1_ready) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
    endtask

    // response ready held low for stall cycles after the request
    task automatic read_counter(input stat_id_t id, input int stall, output stat_cnt_t value);
        rd_req_valid <= 1'b1;
        rd_req_id <= id;
        rd_resp_ready <= (stall == 0);
        @(posedge clk);
        while (!rd_req_ready) begin
            @(posedge clk);
        end
        rd_req_valid <= 1'b0;
        repeat (stall) @(posedge clk);
        rd_resp_ready <= 1'b1;
        @(posedge clk);
        while (!(rd_resp_valid && rd_resp_ready)) begin
            @(posedge clk);
        end
        value = rd_resp_data;
    endtask

    task automatic check_range(input string name, input int first, input int last,
                               input bit stalls);
        stat_cnt_t actual;
        stat_id_t  id;
        integer    r;
        int        stall;
        for (int i = first; i <= last; i++) begin
            id = stat_id_t'(i);
            r = $random(seed);
            stall = stalls ? int'(r[2:0]) : 0;
            read_counter(id, stall, actual);
            assert (actual == ref_cnt[id]) else begin
                $display("mismatch %s counter %0d expected %0d actual %0d",
                         name, id, ref_cnt[id], actual);
                errors++;
            end
        end
    endtask

    initial begin
        integer       r;
        int           sent;
        frame_event_s ev0;
        frame_event_s ev1;
        seed = 34;
        errors = 0;
        cycle_count = 0;
        clk = 1'b0;
        rst = 1'b1;
        evt0_valid = 1'b0;
        evt0 = '0;
        evt1_valid = 1'b0;
        evt1 = '0;
        rd_req_valid = 1'b0;
        rd_req_id = '0;
        rd_resp_ready = 1'b1;
        for (int i = 0; i < STAT_COUNT; i++) begin
            ref_cnt[i] = '0;
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_range("reset_zero", 0, STAT_COUNT - 1, 1'b0);

        // good frames on port 0 only
        for (int i = 0; i < 20; i++) begin
            send_event(0, random_event(1));
        end
        drain();
        check_range("port0_good", 0, 7, 1'b0);

        // bad frames on port 1 only
        for (int i = 0; i < 15; i++) begin
            send_event(1, random_event(2));
        end
        drain();
        check_range("port1_bad", 0, 7, 1'b0);

        // mostly both ports at once to keep the mux busy
        sent = 0;
        while (sent < RANDOM_EVENTS) begin
            r = $random(seed);
            ev0 = random_event(0);
            ev1 = random_event(0);
            if (r[1:0] == 2'd0) begin
                send_event(0, ev0);
                sent += 1;
            end else if (r[1:0] == 2'd1 || sent == RANDOM_EVENTS - 1) begin
                send_event(1, ev1);
                sent += 1;
            end else begin
                fork
                    send_event(0, ev0);
                    send_event(1, ev1);
                join
                sent += 2;
            end
        end
        drain();
        check_range("random_both", 0, 7, 1'b0);

        check_range("read_backpressure", 0, 7, 1'b1);
        check_range("unused_zero", 8, STAT_COUNT - 1, 1'b1);

        $display("errors: %0d value mismatches, %0d assertion failures",
                 errors, uut.stat_props.fail_count);
        if (errors == 0 && uut.stat_props.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
